//--- source/decode_pkg.sv
// RV32I decode cluster types; only OP-IMM, AUIPC, OP and LUI groups are decoded, rest is illegal
package decode_pkg;

    // ====================================================================
    // Widths
    // ====================================================================

    // Data, pc and instruction width
    localparam int unsigned XLEN = 32;

    // Integer register file geometry
    localparam int unsigned REG_SEL_W = 5;
    localparam int unsigned NUM_REGS  = 32;

    // Default lane count, overridden from the cluster top
    localparam int unsigned DEF_NUM_LANES = 2;

    typedef logic [XLEN-1:0]      word_t;
    typedef logic [REG_SEL_W-1:0] reg_sel_t;
    typedef logic [2:0]           funct3_t;

    // Opcode group is ir[6:2], ir[1:0] is not checked
    typedef logic [4:0]           opgroup_t;

    // ====================================================================
    // Opcode groups
    // ====================================================================

    // Register-immediate ALU ops
    localparam opgroup_t OPG_OPIMM = 5'b00_100;
    // pc plus upper immediate
    localparam opgroup_t OPG_AUIPC = 5'b00_101;
    // Register-register ALU ops
    localparam opgroup_t OPG_OP    = 5'b01_100;
    // Load upper immediate
    localparam opgroup_t OPG_LUI   = 5'b01_101;

    // ====================================================================
    // Packets
    // ====================================================================

    // Fetch packet, one instruction with its pc
    typedef struct packed {
        word_t pc;
        word_t ir;
    } fetch_pkt_t;

    // Decoded instruction in generic form
    //   rd = ALU(funct3, alt)(op1, op2)
    typedef struct packed {
        word_t    op1;
        word_t    op2;
        funct3_t  funct3;
        logic     alt;      // sub / sra select
        reg_sel_t rd;
        logic     illegal;  // Operands forced to zero when set
    } decoded_t;

endpackage

//--- source/decode_lane_if.sv
// Valid/ready payload link between cluster blocks; payload must hold until vld and rdy meet
interface decode_lane_if #(
    parameter type pkt_t = logic
) ();

    // ====================================================================
    // Link signals
    // ====================================================================

    // Sender has a payload on pkt
    logic vld;

    // Receiver can take the payload this cycle
    logic rdy;

    // Payload, held by the sender until transfer
    pkt_t pkt;

    // Transfer on a rising edge with vld and rdy both high
    // Sender must not drop vld or change pkt before then

    // ====================================================================
    // Views
    // ====================================================================

    // Upstream side
    modport sender (
        output vld,
        output pkt,
        input  rdy
    );

    // Downstream side
    modport receiver (
        input  vld,
        input  pkt,
        output rdy
    );

endinterface

//--- source/fetch_distributor.sv
// Round-robin fetch router; zero latency, a stalled lane blocks input even if others are free
module fetch_distributor #(
    parameter int unsigned NUM_LANES = decode_pkg::DEF_NUM_LANES
) (
    input  logic                   clk,
    input  logic                   rstz,
    input  logic                   in_vld,
    input  decode_pkg::fetch_pkt_t in_pkt,
    output logic                   in_rdy,
    decode_lane_if.sender          lanes [NUM_LANES]
);

    // Pointer needs at least one bit, even with a single lane
    localparam int unsigned PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0]     ptr;
    logic [NUM_LANES-1:0] sel_oh;
    logic [NUM_LANES-1:0] lane_vld;
    logic [NUM_LANES-1:0] lane_rdy;

    // ====================================================================
    // Routing
    // ====================================================================

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_route
        // One-hot lane select from the turn pointer
        assign sel_oh[i] = (ptr == PTR_W'(i));

        // Only the lane on turn sees vld, payload fans out to all
        assign lane_vld[i]  = in_vld && sel_oh[i];
        assign lanes[i].vld = lane_vld[i];
        assign lanes[i].pkt = in_pkt;

        // Collect rdy for the mux below
        assign lane_rdy[i] = lanes[i].rdy;
    end

    // Upstream sees the rdy of the lane on turn
    assign in_rdy = lane_rdy[ptr];

    // ====================================================================
    // Turn pointer
    // ====================================================================

    // Advance on every input transfer, wrap after the last lane
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            ptr <= '0;
        end else if (in_vld && in_rdy) begin
            ptr <= (ptr == PTR_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

    // Never offer the same packet to two lanes
    assert property (@(posedge clk) disable iff (~rstz) $onehot0(lane_vld))
        else $error("fetch packet offered to more than one lane");

    // Fetch side keeps vld and payload while the lane on turn stalls
    assert property (@(posedge clk) disable iff (~rstz)
        (in_vld && !in_rdy) |=> (in_vld && $stable(in_pkt)))
        else $error("fetch packet dropped or changed before transfer");

endmodule

//--- source/decode_lane.sv
// Two-cycle RV32I decode lane; own register copy, no forwarding or hazard checks, ir[1:0] ignored
module decode_lane (
    input  logic                 clk,
    input  logic                 rstz,
    // Shared register write port
    input  logic                 regwr_en,
    input  decode_pkg::reg_sel_t regwr_sel,
    input  decode_pkg::word_t    regwr_data,
    // Fetch packet in, decoded result out
    decode_lane_if.receiver      up,
    decode_lane_if.sender        down
);

    typedef enum logic {
        ID1,
        ID2
    } lane_state_e;

    lane_state_e state;
    lane_state_e next_state;

    decode_pkg::fetch_pkt_t in_pkt;
    decode_pkg::opgroup_t   opg;
    decode_pkg::reg_sel_t   rs1;
    decode_pkg::reg_sel_t   rs2;
    decode_pkg::funct3_t    funct3;
    decode_pkg::word_t      imm_i;
    decode_pkg::word_t      imm_u;

    // Combinational decode of the incoming ir
    decode_pkg::word_t dec_op1;
    decode_pkg::word_t dec_op2;
    logic              dec_alt;
    logic              dec_illegal;
    logic              dec_rs1_read;
    logic              dec_rs2_read;

    // Register copies, one per read port
    decode_pkg::word_t reg1 [decode_pkg::NUM_REGS];
    decode_pkg::word_t reg2 [decode_pkg::NUM_REGS];

    decode_pkg::word_t regrd_rs1;
    decode_pkg::word_t regrd_rs2;

    // Operand source flags carried into ID2
    logic rs1_read_q;
    logic rs2_read_q;

    logic                 accept;
    logic                 out_vld_q;
    decode_pkg::decoded_t res_q;

    // ====================================================================
    // Instruction fields
    // ====================================================================

    assign in_pkt = up.pkt;

    assign opg    = in_pkt.ir[6:2];
    assign rs1    = in_pkt.ir[19:15];
    assign rs2    = in_pkt.ir[24:20];
    assign funct3 = in_pkt.ir[14:12];

    // Sign-extended I immediate
    assign imm_i = {{20{in_pkt.ir[31]}}, in_pkt.ir[31:20]};
    // Upper U immediate, low 12 bits clear
    assign imm_u = {in_pkt.ir[31:12], 12'h000};

    // ====================================================================
    // Decoder
    // ====================================================================

    always_comb begin
        dec_op1      = '0;
        dec_op2      = '0;
        dec_alt      = 1'b0;
        dec_illegal  = 1'b0;
        dec_rs1_read = 1'b0;
        dec_rs2_read = 1'b0;
        case (opg)
            decode_pkg::OPG_OPIMM: begin
                dec_rs1_read = 1'b1;
                dec_op2      = imm_i;
                // Only srai uses bit 30, elsewhere it is immediate data
                dec_alt      = (funct3 == 3'b101) && in_pkt.ir[30];
            end
            decode_pkg::OPG_OP: begin
                dec_rs1_read = 1'b1;
                dec_rs2_read = 1'b1;
                dec_alt      = in_pkt.ir[30];
            end
            decode_pkg::OPG_LUI: begin
                dec_op2 = imm_u;
            end
            decode_pkg::OPG_AUIPC: begin
                dec_op1 = in_pkt.pc;
                dec_op2 = imm_u;
            end
            // All-zero and all-one groups land here too
            default: begin
                dec_illegal = 1'b1;
            end
        endcase
    end

    // ====================================================================
    // Integer registers
    // ====================================================================

    // Write port, x0 stays unwritten
    always_ff @(posedge clk) begin
        if (regwr_en && (regwr_sel != '0)) begin
            reg1[regwr_sel] <= regwr_data;
            reg2[regwr_sel] <= regwr_data;
        end
    end

    // Read on the accepting edge, same-edge write is not seen
    always_ff @(posedge clk) begin
        if (accept) begin
            regrd_rs1 <= (rs1 == '0) ? '0 : reg1[rs1];
            regrd_rs2 <= (rs2 == '0) ? '0 : reg2[rs2];
        end
    end

    // ====================================================================
    // Sequencer
    // ====================================================================

    // Take a packet in ID1 when the output slot is empty or draining
    assign up.rdy = (state == ID1) && (~out_vld_q || down.rdy);
    assign accept = up.vld && up.rdy;

    always_comb begin
        next_state = state;
        case (state)
            ID1: if (accept) next_state = ID2;
            ID2: next_state = ID1;
            default: next_state = ID1;
        endcase
    end

    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            state <= ID1;
        end else begin
            state <= next_state;
        end
    end

    // Output valid, set at the end of ID2 and held until taken
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            out_vld_q <= 1'b0;
        end else if (state == ID2) begin
            out_vld_q <= 1'b1;
        end else if (out_vld_q && down.rdy) begin
            out_vld_q <= 1'b0;
        end
    end

    // ====================================================================
    // Result
    // ====================================================================

    always_ff @(posedge clk) begin
        if (accept) begin
            // Immediate or pc parked in the operands for now
            res_q.op1     <= dec_op1;
            res_q.op2     <= dec_op2;
            res_q.funct3  <= funct3;
            res_q.alt     <= dec_alt;
            res_q.rd      <= in_pkt.ir[11:7];
            res_q.illegal <= dec_illegal;
            rs1_read_q    <= dec_rs1_read;
            rs2_read_q    <= dec_rs2_read;
        end else if (state == ID2) begin
            // Register data is ready now
            if (rs1_read_q) res_q.op1 <= regrd_rs1;
            if (rs2_read_q) res_q.op2 <= regrd_rs2;
        end
    end

    assign down.vld = out_vld_q;
    assign down.pkt = res_q;

    // Stalled result keeps its vld and payload
    assert property (@(posedge clk) disable iff (~rstz)
        (down.vld && !down.rdy) |=> (down.vld && $stable(down.pkt)))
        else $error("lane result changed while stalled");

    // No new packet while operands are being finished
    assert property (@(posedge clk) disable iff (~rstz) (state == ID2) |-> !up.rdy)
        else $error("lane ready in ID2");

endmodule

//--- source/decode_collector.sv
// In-order result merge; follows the input turn order, so a slow lane holds back the rest
module decode_collector #(
    parameter int unsigned NUM_LANES = decode_pkg::DEF_NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rstz,
    input  logic                 out_rdy,
    decode_lane_if.receiver      lanes [NUM_LANES],
    output logic                 out_vld,
    output decode_pkg::decoded_t out_res
);

    // Same pointer sizing as the distributor
    localparam int unsigned PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

    logic [PTR_W-1:0]     ptr;
    logic [NUM_LANES-1:0] sel_oh;
    logic [NUM_LANES-1:0] lane_vld;
    logic [NUM_LANES-1:0] lane_take;

    decode_pkg::decoded_t lane_res [NUM_LANES];

    // ====================================================================
    // Selection
    // ====================================================================

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_sel
        assign sel_oh[i] = (ptr == PTR_W'(i));

        // Gather lane outputs for the output mux
        assign lane_vld[i] = lanes[i].vld;
        assign lane_res[i] = lanes[i].pkt;

        // Only the lane on turn is drained
        assign lanes[i].rdy = out_rdy && sel_oh[i];

        // Per-lane transfer, checked below
        assign lane_take[i] = lanes[i].vld && lanes[i].rdy;
    end

    // Present the lane on turn, others wait
    assign out_vld = lane_vld[ptr];
    assign out_res = lane_res[ptr];

    // ====================================================================
    // Turn pointer
    // ====================================================================

    // Advance on every output transfer, wraps like the input pointer
    always_ff @(posedge clk or negedge rstz) begin
        if (~rstz) begin
            ptr <= '0;
        end else if (out_vld && out_rdy) begin
            ptr <= (ptr == PTR_W'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
        end
    end

    // Any lane drained off turn would break program order
    assert property (@(posedge clk) disable iff (~rstz) (lane_take & ~sel_oh) == '0)
        else $error("result taken from a lane off turn");

    // Output held under back-pressure
    assert property (@(posedge clk) disable iff (~rstz)
        (out_vld && !out_rdy) |=> (out_vld && $stable(out_res)))
        else $error("cluster output changed while stalled");

endmodule

//--- source/decode_cluster.sv
// Decode cluster top; NUM_LANES >= 1, out_rdy to in_rdy is a combinational path
module decode_cluster #(
    parameter int unsigned NUM_LANES = decode_pkg::DEF_NUM_LANES
) (
    input  logic                 clk,
    input  logic                 rstz,
    // Fetch side
    input  logic                 in_vld,
    output logic                 in_rdy,
    input  decode_pkg::word_t    in_pc,
    input  decode_pkg::word_t    in_ir,
    // Execute side
    output logic                 out_vld,
    input  logic                 out_rdy,
    output decode_pkg::word_t    out_op1,
    output decode_pkg::word_t    out_op2,
    output decode_pkg::funct3_t  out_funct3,
    output logic                 out_alt,
    output decode_pkg::reg_sel_t out_rd,
    output logic                 out_illegal,
    // Register write port, shared by every lane copy
    input  logic                 regwr_en,
    input  decode_pkg::reg_sel_t regwr_sel,
    input  decode_pkg::word_t    regwr_data
);

    decode_pkg::fetch_pkt_t in_pkt;
    decode_pkg::decoded_t   out_res;

    // Distributor to lanes
    decode_lane_if #(.pkt_t(decode_pkg::fetch_pkt_t)) fetch_link [NUM_LANES] ();

    // Lanes to collector
    decode_lane_if #(.pkt_t(decode_pkg::decoded_t)) dec_link [NUM_LANES] ();

    // Pack the fetch ports
    assign in_pkt.pc = in_pc;
    assign in_pkt.ir = in_ir;

    // ====================================================================
    // Input turn
    // ====================================================================

    fetch_distributor #(
        .NUM_LANES (NUM_LANES)
    ) dist0 (
        .clk    (clk),
        .rstz   (rstz),
        .in_vld (in_vld),
        .in_pkt (in_pkt),
        .in_rdy (in_rdy),
        .lanes  (fetch_link)
    );

    // ====================================================================
    // Lanes
    // ====================================================================

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        decode_lane lane (
            .clk        (clk),
            .rstz       (rstz),
            .regwr_en   (regwr_en),
            .regwr_sel  (regwr_sel),
            .regwr_data (regwr_data),
            .up         (fetch_link[g]),
            .down       (dec_link[g])
        );
    end

    // ====================================================================
    // Output turn
    // ====================================================================

    decode_collector #(
        .NUM_LANES (NUM_LANES)
    ) coll0 (
        .clk     (clk),
        .rstz    (rstz),
        .out_rdy (out_rdy),
        .lanes   (dec_link),
        .out_vld (out_vld),
        .out_res (out_res)
    );

    // Unpack the result
    assign out_op1     = out_res.op1;
    assign out_op2     = out_res.op2;
    assign out_funct3  = out_res.funct3;
    assign out_alt     = out_res.alt;
    assign out_rd      = out_res.rd;
    assign out_illegal = out_res.illegal;

endmodule

//--- test/decode_vectors.svh
// Decode table for the cluster testbench; x5 is rewritten before entry REWRITE_AT, pcs are arbitrary

localparam int NUM_VEC = 20;

// Section two starts here, x5 gets a new value first
localparam int                   REWRITE_AT  = 13;
localparam decode_pkg::reg_sel_t REWRITE_REG = 5'd5;
localparam decode_pkg::word_t    REWRITE_VAL = 32'h5a5a_0f0f;

// Columns: name, pc, ir, op1 kind, op1 reg, op2 kind, op2 imm or reg, funct3, rd, {alt, illegal}
localparam vec_t VEC_TAB [NUM_VEC] = '{
    '{"addi_pos", 32'h100, 32'h00508193, K_REG, 5'd1, K_IMM, 32'h00000005, 3'd0, 5'd3, 2'b00},
    '{"addi_neg", 32'h104, 32'hfff10213, K_REG, 5'd2, K_IMM, 32'hffffffff, 3'd0, 5'd4, 2'b00},
    '{"addi_x0", 32'h108, 32'h80000293, K_REG, 5'd0, K_IMM, 32'hfffff800, 3'd0, 5'd5, 2'b00},
    '{"srai", 32'h10c, 32'h4033d313, K_REG, 5'd7, K_IMM, 32'h00000403, 3'd5, 5'd6, 2'b10},
    '{"srli", 32'h110, 32'h0044d413, K_REG, 5'd9, K_IMM, 32'h00000004, 3'd5, 5'd8, 2'b00},
    '{"add", 32'h114, 32'h00c58533, K_REG, 5'd11, K_REG, 32'd12, 3'd0, 5'd10, 2'b00},
    '{"sub", 32'h118, 32'h40f706b3, K_REG, 5'd14, K_REG, 32'd15, 3'd0, 5'd13, 2'b10},
    '{"xor_x0", 32'h11c, 32'h00504833, K_REG, 5'd0, K_REG, 32'd5, 3'd4, 5'd16, 2'b00},
    '{"lui", 32'h120, 32'habcde8b7, K_ZERO, 5'd0, K_IMM, 32'habcde000, 3'd6, 5'd17, 2'b00},
    '{"auipc", 32'h1000, 32'h12345917, K_PC, 5'd0, K_IMM, 32'h12345000, 3'd5, 5'd18, 2'b00},
    '{"ill_zero", 32'h128, 32'h00000000, K_ZERO, 5'd0, K_ZERO, 32'h0, 3'd0, 5'd0, 2'b01},
    '{"ill_ones", 32'h12c, 32'hffffffff, K_ZERO, 5'd0, K_ZERO, 32'h0, 3'd7, 5'd31, 2'b01},
    '{"ill_sw", 32'h130, 32'h00312223, K_ZERO, 5'd0, K_ZERO, 32'h0, 3'd2, 5'd4, 2'b01},
    '{"add_new", 32'h134, 32'h005289b3, K_REG, 5'd5, K_REG, 32'd5, 3'd0, 5'd19, 2'b00},
    '{"or_new", 32'h138, 32'h0012ea33, K_REG, 5'd5, K_REG, 32'd1, 3'd6, 5'd20, 2'b00},
    '{"ill_jal", 32'h13c, 32'h000000ef, K_ZERO, 5'd0, K_ZERO, 32'h0, 3'd0, 5'd1, 2'b01},
    '{"slli", 32'h140, 32'h001b1a93, K_REG, 5'd22, K_IMM, 32'h00000001, 3'd1, 5'd21, 2'b00},
    '{"andi_b30", 32'h144, 32'h7ffc7b93, K_REG, 5'd24, K_IMM, 32'h000007ff, 3'd7, 5'd23, 2'b00},
    '{"auipc_hi", 32'h80000004, 32'hfffffc97, K_PC, 5'd0, K_IMM, 32'hfffff000, 3'd7, 5'd25, 2'b00},
    '{"sub_x0", 32'h14c, 32'h41b00d33, K_REG, 5'd0, K_REG, 32'd27, 3'd0, 5'd26, 2'b10}
};

//--- test/decode_cluster_tb.sv
// Decode cluster testbench at NUM_LANES 2; needs timing support, results are checked in input order
module decode_cluster_tb;

    localparam int RST_CYCLES = 10;

    // Operand source kinds used by the table
    localparam logic [1:0] K_ZERO = 2'd0;
    localparam logic [1:0] K_PC   = 2'd1;
    localparam logic [1:0] K_REG  = 2'd2;
    localparam logic [1:0] K_IMM  = 2'd3;

    typedef struct packed {
        logic [63:0]          name;
        decode_pkg::word_t    pc;
        decode_pkg::word_t    ir;
        logic [1:0]           a_kind;
        decode_pkg::reg_sel_t a_reg;
        logic [1:0]           b_kind;
        decode_pkg::word_t    b_val;   // Immediate, or register index for K_REG
        decode_pkg::funct3_t  funct3;
        decode_pkg::reg_sel_t rd;
        logic [1:0]           flags;   // {alt, illegal}
    } vec_t;

    `include "decode_vectors.svh"

    // Reset, preload, table and a tail of idle cycles
    localparam int TIMEOUT = NUM_VEC * 20 + 34 + RST_CYCLES + 8;

    logic clk;
    logic rstz;
    logic in_vld;
    logic in_rdy;
    logic out_vld;
    logic out_rdy;
    logic out_alt;
    logic out_illegal;
    logic regwr_en;
    decode_pkg::word_t    in_pc;
    decode_pkg::word_t    in_ir;
    decode_pkg::word_t    out_op1;
    decode_pkg::word_t    out_op2;
    decode_pkg::funct3_t  out_funct3;
    decode_pkg::reg_sel_t out_rd;
    decode_pkg::reg_sel_t regwr_sel;
    decode_pkg::word_t    regwr_data;

    // Register model, x0 never written
    decode_pkg::word_t    model_regs [32];
    decode_pkg::decoded_t exp_q [$];

    logic [31:0] rnd_state = 32'd65;
    logic        stall_on = 1'b0;
    int          cycles = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          n_results = 0;

    decode_cluster #(
        .NUM_LANES (2)
    ) dut0 (
        .clk (clk), .rstz (rstz),
        .in_vld (in_vld), .in_rdy (in_rdy), .in_pc (in_pc), .in_ir (in_ir),
        .out_vld (out_vld), .out_rdy (out_rdy),
        .out_op1 (out_op1), .out_op2 (out_op2), .out_funct3 (out_funct3),
        .out_alt (out_alt), .out_rd (out_rd), .out_illegal (out_illegal),
        .regwr_en (regwr_en), .regwr_sel (regwr_sel), .regwr_data (regwr_data)
    );

    // ====================================================================
    // Helpers
    // ====================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Packed name back to text, leading null bytes dropped
    function automatic string vec_name(input logic [63:0] raw);
        string s;
        s = "";
        for (int b = 7; b >= 0; b--) begin
            if (raw[b*8 +: 8] != 8'h00) s = {s, $sformatf("%c", raw[b*8 +: 8])};
        end
        return s;
    endfunction

    function automatic decode_pkg::word_t operand_value(input logic [1:0] kind,
            input decode_pkg::reg_sel_t sel, input decode_pkg::word_t pc,
            input decode_pkg::word_t imm);
        case (kind)
            K_PC:    return pc;
            K_REG:   return model_regs[sel];
            K_IMM:   return imm;
            default: return '0;
        endcase
    endfunction

    // Expected result from the table row and the current register model
    function automatic decode_pkg::decoded_t expected_result(input vec_t v);
        decode_pkg::decoded_t e;
        e.op1     = operand_value(v.a_kind, v.a_reg, v.pc, '0);
        e.op2     = operand_value(v.b_kind, v.b_val[4:0], v.pc, v.b_val);
        e.funct3  = v.funct3;
        e.alt     = v.flags[1];
        e.rd      = v.rd;
        e.illegal = v.flags[0];
        return e;
    endfunction

    // Write lands on the next edge, model follows the x0 rule
    task automatic write_reg(input decode_pkg::reg_sel_t sel, input decode_pkg::word_t data);
        regwr_en   = 1'b1;
        regwr_sel  = sel;
        regwr_data = data;
        if (sel != '0) model_regs[sel] = data;
    endtask

    task automatic check_word(input string tname, input string field,
            input decode_pkg::word_t exp, input decode_pkg::word_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s %s expected %h actual %h", tname, field, exp, act);
        end
    endtask

    task automatic check_sel(input string tname, input string field,
            input decode_pkg::reg_sel_t exp, input decode_pkg::reg_sel_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s %s expected %0d actual %0d", tname, field, exp, act);
        end
    endtask

    task automatic check_funct3(input string tname, input string field,
            input decode_pkg::funct3_t exp, input decode_pkg::funct3_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s %s expected %b actual %b", tname, field, exp, act);
        end
    endtask

    task automatic check_flag(input string tname, input string field,
            input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("ERR %s %s expected %b actual %b", tname, field, exp, act);
        end
    endtask

    // ====================================================================
    // Stimulus and result collection
    // ====================================================================

    task automatic drive_inputs();
        vec_t v;
        for (int i = 0; i < NUM_VEC; i++) begin
            v = VEC_TAB[i];
            if (i == REWRITE_AT) begin
                // Idle cycle with the register write, next entry reads the new value
                in_vld = 1'b0;
                write_reg(REWRITE_REG, REWRITE_VAL);
                @(posedge clk);
                #1;
                regwr_en = 1'b0;
            end
            in_vld = 1'b1;
            in_pc  = v.pc;
            in_ir  = v.ir;
            exp_q.push_back(expected_result(v));
            // Transfer happens on the edge after a ready mid-cycle sample
            @(negedge clk);
            while (!in_rdy) @(negedge clk);
            @(posedge clk);
            #1;
        end
        in_vld = 1'b0;
    endtask

    task automatic collect_results();
        decode_pkg::decoded_t exp;
        string                tname;
        int                   err_before;
        while (n_results < NUM_VEC) begin
            @(negedge clk);
            if (out_vld && out_rdy) begin
                tname      = vec_name(VEC_TAB[n_results].name);
                err_before = n_errors;
                if (exp_q.size() == 0) begin
                    n_errors++;
                    $display("result for %s came out before it was sent", tname);
                end else begin
                    exp = exp_q.pop_front();
                    check_word(tname, "op1", exp.op1, out_op1);
                    check_word(tname, "op2", exp.op2, out_op2);
                    check_funct3(tname, "funct3", exp.funct3, out_funct3);
                    check_flag(tname, "alt", exp.alt, out_alt);
                    check_sel(tname, "rd", exp.rd, out_rd);
                    check_flag(tname, "illegal", exp.illegal, out_illegal);
                end
                $display("%s %s", (n_errors == err_before) ? "ok  " : "fail", tname);
                n_results++;
            end
        end
    endtask

    // ====================================================================
    // Clock, stalls, timeout
    // ====================================================================

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Random back-pressure, roughly one cycle in three
    initial begin
        out_rdy = 1'b0;
        wait (stall_on);
        forever begin
            @(posedge clk);
            #1;
            rnd_state = xorshift32(rnd_state);
            out_rdy   = (rnd_state[3:0] > 4'd4);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, stopped waiting for results (%0d of %0d)",
                     cycles, n_results, NUM_VEC);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ====================================================================
    // Main sequence
    // ====================================================================

    initial begin
        int reset_err;
        rstz       = 1'b0;
        in_vld     = 1'b0;
        in_pc      = '0;
        in_ir      = '0;
        regwr_en   = 1'b0;
        regwr_sel  = '0;
        regwr_data = '0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstz = 1'b1;

        // Idle cluster after reset
        @(negedge clk);
        reset_err = n_errors;
        check_flag("reset", "out_vld", 1'b0, out_vld);
        check_flag("reset", "in_rdy", 1'b1, in_rdy);
        $display("%s %s", (n_errors == reset_err) ? "ok  " : "fail", "reset");

        // Preload, x0 gets a nonzero attempt too
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            #1;
            rnd_state = xorshift32(rnd_state);
            write_reg(decode_pkg::reg_sel_t'(r), rnd_state);
        end
        @(posedge clk);
        #1;
        regwr_en = 1'b0;

        stall_on = 1'b1;
        fork
            drive_inputs();
            collect_results();
        join

        // Nothing beyond the table may appear
        repeat (8) begin
            @(negedge clk);
            if (out_vld) begin
                n_errors++;
                $display("extra result on the output after the last instruction");
                break;
            end
        end

        $display("checks %0d, errors %0d, results %0d of %0d",
                 n_checks, n_errors, n_results, NUM_VEC);
        if ((n_errors == 0) && (n_results == NUM_VEC)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+test
source/decode_pkg.sv
source/decode_lane_if.sv
source/fetch_distributor.sv
source/decode_lane.sv
source/decode_collector.sv
source/decode_cluster.sv
test/decode_cluster_tb.sv

//--- Makefile
TOP := decode_cluster_tb

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
